// ==== microControl.f ====
design/ksDataPkg.sv
design/ksMicroPkg.sv
design/controlStore.sv
design/microDispatch.sv
design/microSkip.sv
design/microSequencer.sv
design/microControl.sv
tests/microControl_checker.sv
tests/microControl_tb.sv

// ==== Makefile ====
# Verilator flow for the microcode control section

TOP := microControl_tb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f microControl.f --top-module microControl

sim:
	verilator --binary --timing --assert -j 0 -f microControl.f \
		--top-module $(TOP) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

// ==== tests/microControl_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module microControl_tb;

   localparam int aw = ksDataPkg::addrWidth;
   localparam int cw = ksMicroPkg::cromWidth;

   logic clk = 1'b0;
   logic rstN;
   logic run;
   logic loadEn;
   logic [0:aw-1] loadAddr;
   logic [0:cw-1] loadData;
   logic [0:ksDataPkg::dataWidth-1] dp;
   logic [0:ksDataPkg::flagCount-1] flags;
   logic [0:11] dispDiag, dispJ, dispAread;
   logic [8:11] dispMul, dispPf, dispNi, dispByte, dispEa, dispScad;
   logic [8:11] dispNorm, dispDromA, dispDromB;
   wire  [0:aw-1] microPC;
   wire  [0:cw-1] crom;

   logic [31:0] rngState = 32'h8b0f_4a6a;
   // Where the machine should sit and the expected return stack
   logic [0:aw-1] pcModel;
   logic [0:aw-1] retModel[$];

   always #10 clk = ~clk;

   microControl u_dut
     (.clk(clk), .rstN(rstN), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
      .loadData(loadData), .dp(dp), .flags(flags), .dispDiag(dispDiag), .dispJ(dispJ),
      .dispAread(dispAread), .dispMul(dispMul), .dispPf(dispPf), .dispNi(dispNi),
      .dispByte(dispByte), .dispEa(dispEa), .dispScad(dispScad), .dispNorm(dispNorm),
      .dispDromA(dispDromA), .dispDromB(dispDromB), .microPC(microPC), .crom(crom));

   bind microSequencer microControl_checker uChecker
     (.clk(clk), .rstN(rstN), .run(run), .microPC(microPC), .doPush(doPush),
      .doPop(doPop), .stackFull(stackFull), .stackEmpty(stackEmpty));

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus and reference helpers
   ////////////////////////////////////////////////////////////////////////////

   // Xorshift32
   function automatic logic [31:0] nextRand();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   function automatic logic [0:cw-1] makeWord(input logic [0:aw-1] j, input logic en10,
         input logic en20, input logic en40, input logic [1:0] selH, input logic [2:0] sel,
         input logic [2:0] skip, input logic [1:0] op);
      logic [0:cw-1] w;
      w = '0;
      w[ksMicroPkg::jFieldPos +: ksMicroPkg::jFieldWidth] = j;
      w[ksMicroPkg::dispEn10Pos] = en10;
      w[ksMicroPkg::dispEn20Pos] = en20;
      w[ksMicroPkg::dispEn40Pos] = en40;
      w[ksMicroPkg::dispSelHPos +: ksMicroPkg::dispSelHWidth] = selH;
      w[ksMicroPkg::dispSelPos +: ksMicroPkg::dispSelWidth] = sel;
      w[ksMicroPkg::skipSelPos +: ksMicroPkg::skipSelWidth] = skip;
      w[ksMicroPkg::seqOpPos +: ksMicroPkg::seqOpWidth] = op;
      return w;
   endfunction

   // jField OR dispatch OR skip with top as the return source
   function automatic logic [0:aw-1] expectNext(input logic [0:cw-1] w,
         input logic [0:aw-1] top);
      logic [0:aw-1] addr;
      logic [1:0] selH;
      logic [2:0] sel;
      logic [2:0] skip;
      logic [0:3] low;
      logic skipHit;
      addr = w[ksMicroPkg::jFieldPos +: ksMicroPkg::jFieldWidth];
      selH = w[ksMicroPkg::dispSelHPos +: ksMicroPkg::dispSelHWidth];
      sel  = w[ksMicroPkg::dispSelPos +: ksMicroPkg::dispSelWidth];
      skip = w[ksMicroPkg::skipSelPos +: ksMicroPkg::skipSelWidth];
      low  = 4'b0000;
      // High half is bits 0 to 7
      if (w[ksMicroPkg::dispEn20Pos])
         case (selH)
            ksMicroPkg::selHDiag  : addr[0:7] = addr[0:7] | dispDiag[0:7];
            ksMicroPkg::selHRet   : addr[0:7] = addr[0:7] | top[0:7];
            ksMicroPkg::selHJ     : addr[0:7] = addr[0:7] | dispJ[0:7];
            default               : addr[0:7] = addr[0:7] | dispAread[0:7];
         endcase
      if (w[ksMicroPkg::dispEn10Pos])
         case (sel)
            ksMicroPkg::sel10Diag : low = dispDiag[8:11];
            ksMicroPkg::sel10Ret  : low = top[8:11];
            ksMicroPkg::sel10Mul  : low = dispMul;
            ksMicroPkg::sel10Pf   : low = dispPf;
            ksMicroPkg::sel10Ni   : low = dispNi;
            ksMicroPkg::sel10Byte : low = dispByte;
            ksMicroPkg::sel10Ea   : low = dispEa;
            default               : low = dispScad;
         endcase
      // EN40 source wins over EN10
      if (w[ksMicroPkg::dispEn40Pos])
         case (sel)
            ksMicroPkg::sel40Zero  : low = 4'b0000;
            ksMicroPkg::sel40Dp18  : low = dp[18:21];
            ksMicroPkg::sel40J     : low = dispJ[8:11];
            ksMicroPkg::sel40Aread : low = dispAread[8:11];
            ksMicroPkg::sel40Norm  : low = dispNorm;
            ksMicroPkg::sel40Dp32  : low = dp[32:35];
            ksMicroPkg::sel40DromA : low = dispDromA;
            default                : low = dispDromB;
         endcase
      addr[8:11] = addr[8:11] | low;
      case (skip)
         ksMicroPkg::skipDpSign : skipHit = dp[0];
         ksMicroPkg::skipDpZero : skipHit = (dp == '0);
         ksMicroPkg::skipFlag0  : skipHit = flags[0];
         ksMicroPkg::skipFlag1  : skipHit = flags[1];
         ksMicroPkg::skipFlag2  : skipHit = flags[2];
         ksMicroPkg::skipFlag3  : skipHit = flags[3];
         default                : skipHit = 1'b0;
      endcase
      addr[11] = addr[11] | skipHit;
      return addr;
   endfunction

   task automatic stopRun();
      $display("Test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkPC(input logic [0:aw-1] got, input logic [0:aw-1] exp,
         input string what);
      if (got !== exp)
      begin
         $display("[FAIL] %0t ns %s: microPC is %h, expected %h", $time, what, got, exp);
         stopRun();
      end
   endtask

   task automatic checkWord(input logic [0:cw-1] got, input logic [0:cw-1] exp,
         input string what);
      if (got !== exp)
      begin
         $display("[FAIL] %0t ns %s: crom is %h, expected %h", $time, what, got, exp);
         stopRun();
      end
   endtask

   // Samples microPC mid cycle and returns on the next rising edge
   task automatic checkLanding(input logic [0:aw-1] exp, input string what);
      @(negedge clk);
      checkPC(microPC, exp, what);
      @(posedge clk);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus tasks entered and left just after a rising edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic loadWord(input logic [0:aw-1] addr, input logic [0:cw-1] data);
      loadEn   <= 1'b1;
      loadAddr <= addr;
      loadData <= data;
      @(posedge clk);
      loadEn   <= 1'b0;
   endtask

   // Run held high for exactly n rising edges
   task automatic runCycles(input int n);
      run <= 1'b1;
      repeat (n) @(posedge clk);
      run <= 1'b0;
   endtask

   task automatic randomizeInputs();
      dp        <= {nextRand(), 4'(nextRand())};
      flags     <= 4'(nextRand());
      dispDiag  <= 12'(nextRand());
      dispJ     <= 12'(nextRand());
      dispAread <= 12'(nextRand());
      dispMul   <= 4'(nextRand());
      dispPf    <= 4'(nextRand());
      dispNi    <= 4'(nextRand());
      dispByte  <= 4'(nextRand());
      dispEa    <= 4'(nextRand());
      dispScad  <= 4'(nextRand());
      dispNorm  <= 4'(nextRand());
      dispDromA <= 4'(nextRand());
      dispDromB <= 4'(nextRand());
   endtask

   // Puts w at the current microPC, steps once and checks address and fetched word
   task automatic execWord(input logic [0:cw-1] w, input string what);
      logic [0:cw-1] marker;
      logic [0:cw-1] landWord;
      logic [0:aw-1] top;
      logic [0:aw-1] target;
      marker = cw'(nextRand());
      loadWord(pcModel, w);
      // Stalled reread picks up the new word
      @(posedge clk);
      @(negedge clk);
      checkPC(microPC, pcModel, {what, " stalled"});
      checkWord(crom, w, {what, " stalled"});
      @(posedge clk);
      top      = (retModel.size() > 0) ? retModel[retModel.size()-1] : '0;
      target   = expectNext(w, top);
      landWord = (target == pcModel) ? w : marker;
      if (target != pcModel)
         loadWord(target, marker);
      if (w[ksMicroPkg::seqOpPos +: ksMicroPkg::seqOpWidth] == ksMicroPkg::seqCall
          && retModel.size() < ksDataPkg::stackDepth)
         retModel.push_back(pcModel + 1'b1);
      else if (w[ksMicroPkg::seqOpPos +: ksMicroPkg::seqOpWidth] == ksMicroPkg::seqRet
               && retModel.size() > 0)
         void'(retModel.pop_back());
      runCycles(1);
      @(negedge clk);
      checkPC(microPC, target, what);
      checkWord(crom, landWord, what);
      @(posedge clk);
      pcModel = target;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic testResetStall();
      for (int i = 0; i < 4; i++)
      begin
         @(negedge clk);
         checkPC(microPC, '0, "reset stall");
         checkWord(crom, '0, "reset stall");
         @(posedge clk);
      end
      execWord(makeWord(aw'(nextRand()), 1'b0, 1'b0, 1'b0, 2'd0, 3'd0,
                        ksMicroPkg::skipNone, ksMicroPkg::seqJump), "first word");
   endtask

   task automatic testJumps();
      for (int i = 0; i < 6; i++)
         execWord(makeWord(aw'(nextRand()), 1'b0, 1'b0, 1'b0, 2'd0, 3'd0,
                           ksMicroPkg::skipNone, ksMicroPkg::seqJump), "jump chain");
   endtask

   task automatic testDispatch();
      for (int h = 0; h < 4; h++)
      begin
         randomizeInputs();
         execWord(makeWord(aw'(nextRand()), 1'b0, 1'b1, 1'b0, 2'(h), 3'd0,
                           ksMicroPkg::skipNone, ksMicroPkg::seqJump), "dispatch high");
      end
      // Modes EN10, EN40 and then both
      for (int m = 1; m < 4; m++)
         for (int s = 0; s < 8; s++)
         begin
            randomizeInputs();
            execWord(makeWord(aw'(nextRand()), m[0], 1'b0, m[1], 2'd0, 3'(s),
                              ksMicroPkg::skipNone, ksMicroPkg::seqJump), "dispatch low");
         end
   endtask

   task automatic testSkip();
      for (int s = 0; s < 7; s++)
         for (int k = 0; k < 2; k++)
         begin
            randomizeInputs();
            // Zero datapath word on the second pass
            if (k == 1)
               dp <= '0;
            execWord(makeWord(aw'(nextRand()) & 12'hffe, 1'b0, 1'b0, 1'b0, 2'd0, 3'd0,
                              3'(s), ksMicroPkg::seqJump), "skip");
         end
   endtask

   task automatic testCallReturn();
      logic [0:aw-1] caller;
      logic [0:aw-1] sub1;
      logic [0:cw-1] retWord;
      // RET dispatch on both halves
      retWord = makeWord('0, 1'b1, 1'b1, 1'b0, ksMicroPkg::selHRet, ksMicroPkg::sel10Ret,
                         ksMicroPkg::skipNone, ksMicroPkg::seqRet);
      for (int r = 0; r < 2; r++)
      begin
         caller = pcModel;
         sub1   = aw'(nextRand());
         execWord(makeWord(sub1, 1'b0, 1'b0, 1'b0, 2'd0, 3'd0,
                           ksMicroPkg::skipNone, ksMicroPkg::seqCall), "call level 1");
         execWord(makeWord(aw'(nextRand()), 1'b0, 1'b0, 1'b0, 2'd0, 3'd0,
                           ksMicroPkg::skipNone, ksMicroPkg::seqCall), "call level 2");
         execWord(retWord, "return level 2");
         checkLanding(sub1 + 1'b1, "back in level 1");
         execWord(retWord, "return level 1");
         checkLanding(caller + 1'b1, "back in caller");
      end
   endtask

   initial
   begin
      rstN      <= 1'b0;
      run       <= 1'b0;
      loadEn    <= 1'b0;
      loadAddr  <= '0;
      loadData  <= '0;
      dp        <= '0;
      flags     <= '0;
      dispDiag  <= '0;
      dispJ     <= '0;
      dispAread <= '0;
      dispMul   <= '0;
      dispPf    <= '0;
      dispNi    <= '0;
      dispByte  <= '0;
      dispEa    <= '0;
      dispScad  <= '0;
      dispNorm  <= '0;
      dispDromA <= '0;
      dispDromB <= '0;
      pcModel = '0;
      // Eight edges in reset with word 0 cleared on the way
      repeat (2) @(posedge clk);
      loadWord('0, '0);
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
      testResetStall();
      testJumps();
      testDispatch();
      testSkip();
      testCallReturn();
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/microControl_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

// Sequencer rules, bound into microSequencer
module microControl_checker
  (
   input wire                              clk,
   input wire                              rstN,
   input wire                              run,
   input wire [0:ksDataPkg::addrWidth-1]   microPC,
   input wire                              doPush,
   input wire                              doPop,
   input wire                              stackFull,
   input wire                              stackEmpty
  );

   // Stalled machine keeps its microPC
   pcHeldWhileStalled : assert property (@(posedge clk) disable iff (!rstN)
      !run |=> $stable(microPC))
      else $error("microPC moved while run was low");

   // CALL with every stack entry in use
   noPushWhenFull : assert property (@(posedge clk) disable iff (!rstN)
      doPush |-> !stackFull)
      else $error("push onto a full return stack");

   // RET with nothing to return to
   noPopWhenEmpty : assert property (@(posedge clk) disable iff (!rstN)
      doPop |-> !stackEmpty)
      else $error("pop from an empty return stack");

endmodule

`default_nettype wire

// ==== design/microControl.sv ====
`timescale 1ns/10ps
`default_nettype none

// Microcode control section top
module microControl
  (
   input  wire                                clk,
   input  wire                                rstN,
   input  wire                                run,
   input  wire                                loadEn,
   input  wire  [0:ksDataPkg::addrWidth-1]    loadAddr,
   input  wire  [0:ksMicroPkg::cromWidth-1]   loadData,
   input  wire  [0:ksDataPkg::dataWidth-1]    dp,
   input  wire  [0:ksDataPkg::flagCount-1]    flags,
   input  wire  [0:11]                        dispDiag,
   input  wire  [0:11]                        dispJ,
   input  wire  [0:11]                        dispAread,
   input  wire  [8:11]                        dispMul,
   input  wire  [8:11]                        dispPf,
   input  wire  [8:11]                        dispNi,
   input  wire  [8:11]                        dispByte,
   input  wire  [8:11]                        dispEa,
   input  wire  [8:11]                        dispScad,
   input  wire  [8:11]                        dispNorm,
   input  wire  [8:11]                        dispDromA,
   input  wire  [8:11]                        dispDromB,
   output wire  [0:ksDataPkg::addrWidth-1]    microPC,
   output wire  [0:ksMicroPkg::cromWidth-1]   crom
  );

   wire [0:ksDataPkg::addrWidth-1] readAddr;
   wire [0:ksDataPkg::addrWidth-1] dispAddr;
   wire [0:ksDataPkg::addrWidth-1] retAddr;
   wire                            skipBit;

   // Store writes are ignored while the machine runs
   wire storeLoadEn = loadEn & ~run;

   controlStore uStore
     (.clk(clk), .rstN(rstN), .loadEn(storeLoadEn), .loadAddr(loadAddr),
      .loadData(loadData), .readAddr(readAddr), .crom(crom));

   // Return stack top drives both RET selects
   microDispatch uDispatch
     (.crom(crom), .dp(dp), .dispDiag(dispDiag), .dispRet(retAddr),
      .dispJ(dispJ), .dispAread(dispAread), .dispMul(dispMul), .dispPf(dispPf),
      .dispNi(dispNi), .dispByte(dispByte), .dispEa(dispEa), .dispScad(dispScad),
      .dispNorm(dispNorm), .dispDromA(dispDromA), .dispDromB(dispDromB),
      .dispAddr(dispAddr));

   microSkip uSkip
     (.crom(crom), .dp(dp), .flags(flags), .skipBit(skipBit));

   microSequencer uSequencer
     (.clk(clk), .rstN(rstN), .run(run), .crom(crom), .dispAddr(dispAddr),
      .skipBit(skipBit), .readAddr(readAddr), .retAddr(retAddr),
      .microPC(microPC));

endmodule

`default_nettype wire

// ==== design/microSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

// Microprogram counter, next address OR and the return stack
module microSequencer
  (
   input  wire                                clk,
   input  wire                                rstN,
   input  wire                                run,
   input  wire  [0:ksMicroPkg::cromWidth-1]   crom,
   input  wire  [0:ksDataPkg::addrWidth-1]    dispAddr,
   input  wire                                skipBit,
   output logic [0:ksDataPkg::addrWidth-1]    readAddr,
   output logic [0:ksDataPkg::addrWidth-1]    retAddr,
   output logic [0:ksDataPkg::addrWidth-1]    microPC
  );

   ksMicroPkg::seqOpType seqOp;

   logic [0:ksDataPkg::addrWidth-1]       nextPC;
   logic [0:ksDataPkg::addrWidth-1]       callAddr;
   logic [0:ksDataPkg::addrWidth-1]       stack [0:ksDataPkg::stackDepth-1];
   logic [ksDataPkg::stackPtrWidth-1:0]   stackPtr;
   logic [ksDataPkg::stackPtrWidth-2:0]   topIdx;
   logic                                  stackFull;
   logic                                  stackEmpty;
   logic                                  doPush;
   logic                                  doPop;

   wire [0:ksMicroPkg::jFieldWidth-1] jField =
      crom[ksMicroPkg::jFieldPos +: ksMicroPkg::jFieldWidth];

   assign seqOp =
      ksMicroPkg::seqOpType'(crom[ksMicroPkg::seqOpPos +: ksMicroPkg::seqOpWidth]);

   // Three sources OR'ed, skip only touches bit 11
   assign nextPC = jField | dispAddr | {{(ksDataPkg::addrWidth-1){1'b0}}, skipBit};

   // Stalled machine keeps rereading its own word
   assign readAddr = run ? nextPC : microPC;

   ////////////////////////////////////////////////////////////////////////////
   // Return stack
   ////////////////////////////////////////////////////////////////////////////

   assign stackFull  = (stackPtr == ksDataPkg::stackPtrWidth'(ksDataPkg::stackDepth));
   assign stackEmpty = (stackPtr == '0);
   assign topIdx     = stackPtr[ksDataPkg::stackPtrWidth-2:0] - 1'b1;
   assign callAddr   = microPC + 1'b1;

   // Only advancing cycles move the stack
   assign doPush = run && (seqOp == ksMicroPkg::seqCall);
   assign doPop  = run && (seqOp == ksMicroPkg::seqRet);

   // Top of stack feeds the RET dispatch inputs
   assign retAddr = stackEmpty ? '0 : stack[topIdx];

   always_ff @(posedge clk)
   begin
      if (doPush && !stackFull)
         stack[stackPtr[ksDataPkg::stackPtrWidth-2:0]] <= callAddr;
   end

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         microPC  <= '0;
         stackPtr <= '0;
      end
      else
      begin
         if (run)
            microPC <= nextPC;
         // Overflow and underflow leave the pointer alone
         if (doPush && !stackFull)
            stackPtr <= stackPtr + 1'b1;
         else if (doPop && !stackEmpty)
            stackPtr <= stackPtr - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== design/microSkip.sv ====
`timescale 1ns/10ps
`default_nettype none

// Skip condition select
// Result lands in the LSB of the next microaddress
module microSkip
  (
   input  wire  [0:ksMicroPkg::cromWidth-1] crom,
   input  wire  [0:ksDataPkg::dataWidth-1]  dp,
   input  wire  [0:ksDataPkg::flagCount-1]  flags,
   output logic                             skipBit
  );

   wire [0:ksMicroPkg::skipSelWidth-1] skipField =
      crom[ksMicroPkg::skipSelPos +: ksMicroPkg::skipSelWidth];

   ksMicroPkg::skipSelType skipSel;

   assign skipSel = ksMicroPkg::skipSelType'(skipField);

   // Whole datapath word is zero
   wire dpZero = ~|dp;

   always_comb
   begin
      case (skipSel)
         ksMicroPkg::skipNone   : skipBit = 1'b0;
         // Sign is the MSB, bit 0
         ksMicroPkg::skipDpSign : skipBit = dp[0];
         ksMicroPkg::skipDpZero : skipBit = dpZero;
         ksMicroPkg::skipFlag0  : skipBit = flags[0];
         ksMicroPkg::skipFlag1  : skipBit = flags[1];
         ksMicroPkg::skipFlag2  : skipBit = flags[2];
         ksMicroPkg::skipFlag3  : skipBit = flags[3];
         // Unused code
         default                : skipBit = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/microDispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

// N-way dispatch, only ever sets microaddress bits
module microDispatch
  (
   input  wire  [0:ksMicroPkg::cromWidth-1] crom,
   input  wire  [0:ksDataPkg::dataWidth-1]  dp,
   input  wire  [0:11]                      dispDiag,
   input  wire  [0:11]                      dispRet,
   input  wire  [0:11]                      dispJ,
   input  wire  [0:11]                      dispAread,
   input  wire  [8:11]                      dispMul,
   input  wire  [8:11]                      dispPf,
   input  wire  [8:11]                      dispNi,
   input  wire  [8:11]                      dispByte,
   input  wire  [8:11]                      dispEa,
   input  wire  [8:11]                      dispScad,
   input  wire  [8:11]                      dispNorm,
   input  wire  [8:11]                      dispDromA,
   input  wire  [8:11]                      dispDromB,
   output logic [0:ksDataPkg::addrWidth-1]  dispAddr
  );

   // Enables
   wire dispEn10 = crom[ksMicroPkg::dispEn10Pos];
   wire dispEn20 = crom[ksMicroPkg::dispEn20Pos];
   wire dispEn40 = crom[ksMicroPkg::dispEn40Pos];

   // Raw select fields
   wire [0:ksMicroPkg::dispSelHWidth-1] selHField =
      crom[ksMicroPkg::dispSelHPos +: ksMicroPkg::dispSelHWidth];
   wire [0:ksMicroPkg::dispSelWidth-1]  selField  =
      crom[ksMicroPkg::dispSelPos +: ksMicroPkg::dispSelWidth];

   // Same low select field, read two ways
   ksMicroPkg::dispSelHType  selH;
   ksMicroPkg::dispSel10Type sel10;
   ksMicroPkg::dispSel40Type sel40;

   assign selH  = ksMicroPkg::dispSelHType'(selHField);
   assign sel10 = ksMicroPkg::dispSel10Type'(selField);
   assign sel40 = ksMicroPkg::dispSel40Type'(selField);

   always_comb
   begin
      // Nothing enabled, nothing set
      dispAddr = '0;

      // High half
      if (dispEn20)
      begin
         case (selH)
            ksMicroPkg::selHDiag  : dispAddr[0:7] = dispDiag[0:7];
            ksMicroPkg::selHRet   : dispAddr[0:7] = dispRet[0:7];
            ksMicroPkg::selHJ     : dispAddr[0:7] = dispJ[0:7];
            ksMicroPkg::selHAread : dispAddr[0:7] = dispAread[0:7];
         endcase
      end

      // Low half, EN10 group
      if (dispEn10)
      begin
         case (sel10)
            ksMicroPkg::sel10Diag : dispAddr[8:11] = dispDiag[8:11];
            ksMicroPkg::sel10Ret  : dispAddr[8:11] = dispRet[8:11];
            ksMicroPkg::sel10Mul  : dispAddr[8:11] = dispMul;
            ksMicroPkg::sel10Pf   : dispAddr[8:11] = dispPf;
            ksMicroPkg::sel10Ni   : dispAddr[8:11] = dispNi;
            ksMicroPkg::sel10Byte : dispAddr[8:11] = dispByte;
            ksMicroPkg::sel10Ea   : dispAddr[8:11] = dispEa;
            ksMicroPkg::sel10Scad : dispAddr[8:11] = dispScad;
         endcase
      end

      // Low half, EN40 group, overrides EN10 when both are set
      if (dispEn40)
      begin
         case (sel40)
            ksMicroPkg::sel40Zero  : dispAddr[8:11] = 4'b0000;
            ksMicroPkg::sel40Dp18  : dispAddr[8:11] = dp[18:21];
            ksMicroPkg::sel40J     : dispAddr[8:11] = dispJ[8:11];
            ksMicroPkg::sel40Aread : dispAddr[8:11] = dispAread[8:11];
            ksMicroPkg::sel40Norm  : dispAddr[8:11] = dispNorm;
            ksMicroPkg::sel40Dp32  : dispAddr[8:11] = dp[32:35];
            ksMicroPkg::sel40DromA : dispAddr[8:11] = dispDromA;
            ksMicroPkg::sel40DromB : dispAddr[8:11] = dispDromB;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/controlStore.sv ====
`timescale 1ns/10ps
`default_nettype none

// Writable control store
// Loaded from outside while the machine is stopped, read every cycle
module controlStore
  (
   input  wire                                 clk,
   input  wire                                 rstN,
   input  wire                                 loadEn,
   input  wire  [0:ksDataPkg::addrWidth-1]     loadAddr,
   input  wire  [0:ksMicroPkg::cromWidth-1]    loadData,
   input  wire  [0:ksDataPkg::addrWidth-1]     readAddr,
   output logic [0:ksMicroPkg::cromWidth-1]    crom
  );

   // One word per microaddress
   localparam int depth = 1 << ksDataPkg::addrWidth;

   logic [0:ksMicroPkg::cromWidth-1] store [0:depth-1];

   ////////////////////////////////////////////////////////////////////////////
   // Load port
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (loadEn)
         store[loadAddr] <= loadData;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Registered read
   ////////////////////////////////////////////////////////////////////////////

   // Holds the word at the address the sequencer moves to
   // Zero word after reset is a jump to 0 with nothing enabled
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         crom <= '0;
      else
         crom <= store[readAddr];
   end

endmodule

`default_nettype wire

// ==== design/ksMicroPkg.sv ====
`default_nettype none

// Microinstruction word layout and the sequencing field encodings
package ksMicroPkg;

   localparam int cromWidth = 26;

   ////////////////////////////////////////////////////////////////////////////
   // Field layout, bit 0 is the leftmost bit of the word
   ////////////////////////////////////////////////////////////////////////////

   localparam int jFieldPos     = 0;
   localparam int jFieldWidth   = ksDataPkg::addrWidth;
   localparam int dispEn10Pos   = 12;
   localparam int dispEn20Pos   = 13;
   localparam int dispEn40Pos   = 14;
   localparam int dispSelHPos   = 15;
   localparam int dispSelHWidth = 2;
   localparam int dispSelPos    = 17;
   localparam int dispSelWidth  = 3;
   localparam int skipSelPos    = 20;
   localparam int skipSelWidth  = 3;
   localparam int seqOpPos      = 23;
   localparam int seqOpWidth    = 2;
   // Bit 25 is spare

   ////////////////////////////////////////////////////////////////////////////
   // Encodings, all zero means no dispatch, no skip and a plain jump
   ////////////////////////////////////////////////////////////////////////////

   // Source of address bits 0 to 7
   typedef enum logic [dispSelHWidth-1:0] {
      selHDiag, selHRet, selHJ, selHAread
   } dispSelHType;

   // Source of bits 8 to 11 under EN10
   typedef enum logic [dispSelWidth-1:0] {
      sel10Diag, sel10Ret, sel10Mul, sel10Pf, sel10Ni, sel10Byte, sel10Ea, sel10Scad
   } dispSel10Type;

   // Source of bits 8 to 11 under EN40
   typedef enum logic [dispSelWidth-1:0] {
      sel40Zero, sel40Dp18, sel40J, sel40Aread, sel40Norm, sel40Dp32, sel40DromA, sel40DromB
   } dispSel40Type;

   // Code 7 is unused and never skips
   typedef enum logic [skipSelWidth-1:0] {
      skipNone, skipDpSign, skipDpZero, skipFlag0, skipFlag1, skipFlag2, skipFlag3
   } skipSelType;

   // Code 3 is unused and acts as a jump
   typedef enum logic [seqOpWidth-1:0] {
      seqJump, seqCall, seqRet
   } seqOpType;

endpackage

`default_nettype wire

// ==== design/ksDataPkg.sv ====
`default_nettype none

// Widths shared by the datapath side and the microsequencer
package ksDataPkg;

   // Microaddress, bit 0 is the MSB
   localparam int addrWidth = 12;

   // Datapath word
   localparam int dataWidth = 36;

   // Return stack, pointer counts 0 to stackDepth
   localparam int stackDepth = 4;
   localparam int stackPtrWidth = $clog2(stackDepth) + 1;

   // External skip flags
   localparam int flagCount = 4;

endpackage

`default_nettype wire
